// File: flist.f
+incdir+include
src/i2s_pkg.sv
src/audio_pkg.sv
src/i2s_clock_gen.sv
src/i2s_receiver.sv
src/i2s_transmitter.sv
src/sample_fifo.sv
src/i2s_codec_top.sv
tb/tb_i2s_codec.sv

// File: include/i2s_settings.svh
`ifndef I2S_SETTINGS_SVH
`define I2S_SETTINGS_SVH

// Sample widths per channel
`define RX_SAMPLE_BITS 16
`define TX_SAMPLE_BITS 24

// BCLK periods per channel, so one frame is twice this
`define SLOT_BITS 32

// Half-period dividers in clk_i cycles
`define MCLK_DIV 2
`define BCLK_DIV 4

// Buffer depths in frames
`define RX_FIFO_DEPTH 4
`define TX_FIFO_DEPTH 4

`endif

// File: run.sh
#!/bin/sh
# Compile and run the I2S codec loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f flist.f --top-module tb_i2s_codec -o sim_tb_i2s_codec
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb_i2s_codec)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1

// File: src/audio_pkg.sv
`default_nettype none
`include "i2s_settings.svh"

package audio_pkg;

	typedef logic [`RX_SAMPLE_BITS-1:0] rx_sample_t;
	typedef logic [`TX_SAMPLE_BITS-1:0] tx_sample_t;

	// Stereo frame from the ADC side
	typedef struct packed {
		rx_sample_t left;    // Captured while LRCLK is low
		rx_sample_t right;
	} rx_frame_t;

	// Stereo frame towards the DAC side
	typedef struct packed {
		tx_sample_t left;    // Sent first in each frame
		tx_sample_t right;
	} tx_frame_t;

	// Buffer to producer return path
	typedef struct packed {
		logic ret;    // One credit back, one cycle wide
	} credit_t;

endpackage

`default_nettype wire

// File: src/i2s_clock_gen.sv
`default_nettype none
`include "i2s_settings.svh"

module i2s_clock_gen
	import i2s_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_ni,
	output i2s_pins_t  pins_o,
	output i2s_edges_t edges_o
);

	localparam int unsigned MCLK_W = $clog2(`MCLK_DIV);
	localparam int unsigned BCLK_W = $clog2(`BCLK_DIV);

	logic [MCLK_W-1:0] mclk_cnt_q;
	logic [MCLK_W-1:0] mclk_cnt_d;
	logic [BCLK_W-1:0] bclk_cnt_q;
	logic [BCLK_W-1:0] bclk_cnt_d;
	slot_idx_t         slot_cnt_q;   // BCLK falls within the current channel
	slot_idx_t         slot_cnt_d;
	i2s_pins_t         pins_q;
	i2s_pins_t         pins_d;
	i2s_edges_t        edges_q;
	i2s_edges_t        edges_d;
	logic              mclk_tick;
	logic              bclk_tick;
	logic              slot_end;

	always_comb begin
		mclk_tick  = (mclk_cnt_q == MCLK_W'(`MCLK_DIV - 1));
		bclk_tick  = (bclk_cnt_q == BCLK_W'(`BCLK_DIV - 1));
		slot_end   = (slot_cnt_q == slot_idx_t'(`SLOT_BITS - 1));
		mclk_cnt_d = mclk_tick ? '0 : mclk_cnt_q + 1'b1;
		bclk_cnt_d = bclk_tick ? '0 : bclk_cnt_q + 1'b1;
		pins_d     = pins_q;
		slot_cnt_d = slot_cnt_q;

		if (mclk_tick) begin
			pins_d.mclk = ~pins_q.mclk;
		end
		if (bclk_tick) begin
			pins_d.bclk = ~pins_q.bclk;
		end

		edges_d.bclk_rise = bclk_tick & ~pins_q.bclk;
		edges_d.bclk_fall = bclk_tick & pins_q.bclk;

		// LRCLK only moves together with a BCLK fall
		if (edges_d.bclk_fall) begin
			slot_cnt_d = slot_end ? '0 : slot_cnt_q + 1'b1;
			if (slot_end) begin
				pins_d.lrclk = ~pins_q.lrclk;
			end
		end

		edges_d.lrclk_rise = pins_d.lrclk & ~pins_q.lrclk;
		edges_d.lrclk_fall = ~pins_d.lrclk & pins_q.lrclk;
		edges_d.lrclk      = pins_d.lrclk;
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			mclk_cnt_q <= '0;
			bclk_cnt_q <= '0;
			slot_cnt_q <= '0;
			pins_q     <= '0;   // All pin clocks start low
			edges_q    <= '0;
		end else begin
			mclk_cnt_q <= mclk_cnt_d;
			bclk_cnt_q <= bclk_cnt_d;
			slot_cnt_q <= slot_cnt_d;
			pins_q     <= pins_d;
			edges_q    <= edges_d;   // Pulse lands with the toggle
		end
	end

	assign pins_o  = pins_q;
	assign edges_o = edges_q;

endmodule

`default_nettype wire

// File: src/i2s_codec_top.sv
`default_nettype none
`include "i2s_settings.svh"

module i2s_codec_top
	import i2s_pkg::*;
	import audio_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_ni,

	output logic      ac_mclk_o,
	output logic      ac_bclk_o,
	output logic      ac_lrclk_o,
	output logic      ac_dac_sdata_o,
	input  logic      ac_adc_sdata_i,

	input  logic      tx_push_i,
	input  tx_frame_t tx_frame_i,
	output logic      tx_credit_o,   // Host keeps its own count

	output logic      rx_valid_o,
	output rx_frame_t rx_frame_o,
	input  logic      rx_ready_i,

	output logic      overrun_o,
	output logic      underrun_o
);

	i2s_pins_t  pins;
	i2s_edges_t edges;
	credit_t    rx_credit;
	credit_t    tx_credit;
	logic       rx_push;
	rx_frame_t  rx_push_frame;
	logic       tx_valid;
	logic       tx_ready;
	tx_frame_t  tx_pop_frame;

	i2s_clock_gen u_clock_gen (
		.clk_i   (clk_i),
		.rst_ni  (rst_ni),
		.pins_o  (pins),
		.edges_o (edges)
	);

	i2s_receiver u_receiver (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.edges_i   (edges),
		.sdata_i   (ac_adc_sdata_i),
		.credit_i  (rx_credit),
		.push_o    (rx_push),
		.frame_o   (rx_push_frame),
		.overrun_o (overrun_o)
	);

	sample_fifo #(
		.T_PAYLOAD (rx_frame_t),
		.DEPTH     (`RX_FIFO_DEPTH)
	) u_rx_fifo (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.push_i   (rx_push),
		.data_i   (rx_push_frame),
		.credit_o (rx_credit),
		.valid_o  (rx_valid_o),
		.data_o   (rx_frame_o),
		.ready_i  (rx_ready_i)
	);

	sample_fifo #(
		.T_PAYLOAD (tx_frame_t),
		.DEPTH     (`TX_FIFO_DEPTH)
	) u_tx_fifo (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.push_i   (tx_push_i),
		.data_i   (tx_frame_i),
		.credit_o (tx_credit),
		.valid_o  (tx_valid),
		.data_o   (tx_pop_frame),
		.ready_i  (tx_ready)
	);

	i2s_transmitter u_transmitter (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.edges_i    (edges),
		.valid_i    (tx_valid),
		.frame_i    (tx_pop_frame),
		.ready_o    (tx_ready),
		.sdata_o    (ac_dac_sdata_o),
		.underrun_o (underrun_o)
	);

	assign ac_mclk_o   = pins.mclk;
	assign ac_bclk_o   = pins.bclk;
	assign ac_lrclk_o  = pins.lrclk;
	assign tx_credit_o = tx_credit.ret;

endmodule

`default_nettype wire

// File: src/i2s_pkg.sv
`default_nettype none
`include "i2s_settings.svh"

package i2s_pkg;

	// Bit position inside one channel slot
	typedef logic [$clog2(`SLOT_BITS)-1:0] slot_idx_t;

	// Pin levels driven to the codec
	typedef struct packed {
		logic mclk;
		logic bclk;
		logic lrclk;
	} i2s_pins_t;

	// Edge events, each high in the cycle the pin toggles
	typedef struct packed {
		logic bclk_rise;    // Sampling edge
		logic bclk_fall;    // Launch edge
		logic lrclk_rise;   // Start of right channel
		logic lrclk_fall;   // Start of left channel, new frame
		logic lrclk;        // Low means left
	} i2s_edges_t;

endpackage

`default_nettype wire

// File: src/i2s_receiver.sv
`default_nettype none
`include "i2s_settings.svh"

module i2s_receiver
	import i2s_pkg::*;
	import audio_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_ni,
	input  i2s_edges_t edges_i,
	input  logic       sdata_i,
	input  credit_t    credit_i,
	output logic       push_o,
	output rx_frame_t  frame_o,
	output logic       overrun_o
);

	localparam int unsigned CREDIT_W = $clog2(`RX_FIFO_DEPTH + 1);

	slot_idx_t           bit_idx_q;   // All ones marks the delay bit
	rx_frame_t           shift_q;
	rx_frame_t           frame_q;
	logic [CREDIT_W-1:0] credits_q;
	logic                synced_q;    // A left channel began on an LRCLK edge
	logic                push_q;
	logic                overrun_q;
	logic                frame_end;
	logic                take;
	logic                do_push;

	assign frame_end = edges_i.lrclk_fall & synced_q;
	assign do_push   = frame_end && (credits_q != '0);
	assign take      = edges_i.bclk_rise && (bit_idx_q < slot_idx_t'(`RX_SAMPLE_BITS));

	// Sample capture, bits past the sample width fall through
	always_ff @(posedge clk_i) begin
		if (take) begin
			if (edges_i.lrclk) begin
				shift_q.right <= {shift_q.right[`RX_SAMPLE_BITS-2:0], sdata_i};
			end else begin
				shift_q.left <= {shift_q.left[`RX_SAMPLE_BITS-2:0], sdata_i};
			end
		end
		if (frame_end) begin
			frame_q <= shift_q;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			bit_idx_q <= '1;
			synced_q  <= 1'b0;
			credits_q <= CREDIT_W'(`RX_FIFO_DEPTH);
			push_q    <= 1'b0;
			overrun_q <= 1'b0;
		end else begin
			if (edges_i.lrclk_rise || edges_i.lrclk_fall) begin
				bit_idx_q <= '1;   // First rise still carries the previous channel
			end else if (edges_i.bclk_rise) begin
				bit_idx_q <= bit_idx_q + 1'b1;
			end

			if (edges_i.lrclk_fall) begin
				synced_q <= 1'b1;
			end

			push_q    <= do_push;
			overrun_q <= frame_end && (credits_q == '0);   // Frame dropped

			case ({do_push, credit_i.ret})
				2'b10:   credits_q <= credits_q - 1'b1;
				2'b01:   credits_q <= credits_q + 1'b1;
				default: credits_q <= credits_q;
			endcase
		end
	end

	assign push_o    = push_q;
	assign frame_o   = frame_q;
	assign overrun_o = overrun_q;

endmodule

`default_nettype wire

// File: src/i2s_transmitter.sv
`default_nettype none
`include "i2s_settings.svh"

module i2s_transmitter
	import i2s_pkg::*;
	import audio_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_ni,
	input  i2s_edges_t edges_i,
	input  logic       valid_i,
	input  tx_frame_t  frame_i,
	output logic       ready_o,
	output logic       sdata_o,
	output logic       underrun_o
);

	localparam int unsigned MSB = `TX_SAMPLE_BITS - 1;

	slot_idx_t bit_idx_q;   // Bits sent in the current channel
	tx_frame_t shift_q;
	logic      sdata_q;
	logic      underrun_q;
	logic      lr_edge;
	logic      drive;

	assign lr_edge = edges_i.lrclk_rise | edges_i.lrclk_fall;
	assign drive   = edges_i.bclk_fall && !lr_edge
		&& (bit_idx_q < slot_idx_t'(`TX_SAMPLE_BITS));

	// Frame is taken once per LRCLK period
	assign ready_o = edges_i.lrclk_fall;

	always_ff @(posedge clk_i) begin
		if (edges_i.lrclk_fall) begin
			shift_q <= valid_i ? frame_i : '0;
		end else if (drive) begin
			if (edges_i.lrclk) begin
				shift_q.right <= shift_q.right << 1;
			end else begin
				shift_q.left <= shift_q.left << 1;
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			bit_idx_q  <= '1;   // Silent until the first LRCLK edge
			sdata_q    <= 1'b0;
			underrun_q <= 1'b0;
		end else begin
			underrun_q <= edges_i.lrclk_fall & ~valid_i;

			if (lr_edge) begin
				bit_idx_q <= '0;
				sdata_q   <= 1'b0;   // One-bit delay slot
			end else if (drive) begin
				bit_idx_q <= bit_idx_q + 1'b1;
				sdata_q   <= edges_i.lrclk ? shift_q.right[MSB] : shift_q.left[MSB];
			end else if (edges_i.bclk_fall) begin
				sdata_q <= 1'b0;     // Padding up to the slot end
			end
		end
	end

	assign sdata_o    = sdata_q;
	assign underrun_o = underrun_q;

endmodule

`default_nettype wire

// File: src/sample_fifo.sv
`default_nettype none

module sample_fifo
	import audio_pkg::*;
#(
	parameter type         T_PAYLOAD = logic,
	parameter int unsigned DEPTH     = 4
) (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  logic     push_i,
	input  T_PAYLOAD data_i,
	output credit_t  credit_o,
	output logic     valid_o,
	output T_PAYLOAD data_o,
	input  logic     ready_i
);

	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(DEPTH + 1);

	T_PAYLOAD         mem_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	credit_t          credit_q;
	logic             pop;

	// Pointer wrap also covers depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign valid_o = (count_q != '0);
	assign data_o  = mem_q[rd_ptr_q];
	assign pop     = valid_o & ready_i;

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			mem_q[wr_ptr_q] <= data_i;   // Producer holds a credit, so never full
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			credit_q <= '0;
		end else begin
			credit_q.ret <= pop;   // Freed slot goes back next cycle

			if (push_i) begin
				wr_ptr_q <= ptr_next(wr_ptr_q);
			end
			if (pop) begin
				rd_ptr_q <= ptr_next(rd_ptr_q);
			end

			case ({push_i, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	assign credit_o = credit_q;

endmodule

`default_nettype wire

// File: tb/tb_i2s_codec.sv
`default_nettype none
`include "i2s_settings.svh"

module tb_i2s_codec
	import audio_pkg::*;
();

	localparam int FRAME_CYCLES   = 2 * `SLOT_BITS * 2 * `BCLK_DIV;
	localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES;
	localparam int LOOP_FRAMES    = 12;
	localparam int HOLD_FRAMES    = 8;

	// Comparator modes
	localparam int M_SKIP   = 0;
	localparam int M_LOOP   = 1;
	localparam int M_HOLD   = 2;
	localparam int M_IGNORE = 3;
	localparam int M_STARVE = 4;

	logic      clk_i = 1'b0;
	logic      rst_ni;
	logic      ac_mclk_o;
	logic      ac_bclk_o;
	logic      ac_lrclk_o;
	wire       loop_sdata;   // DAC line fed straight back as ADC line
	logic      tx_push_i;
	tx_frame_t tx_frame_i;
	logic      tx_credit_o;
	logic      rx_valid_o;
	rx_frame_t rx_frame_o;
	logic      rx_ready_i;
	logic      overrun_o;
	logic      underrun_o;

	int          errors = 0;
	int          checks = 0;
	int          cycle_cnt = 0;
	logic [15:0] lfsr_q = 16'd40965;
	int          credits = `TX_FIFO_DEPTH;
	logic        host_en = 1'b1;
	logic        starving = 1'b0;
	rx_frame_t   exp_q [$];
	int          mode = M_SKIP;
	int          matched = 0;
	int          zero_run = 0;
	int          overrun_cnt = 0;
	int          underrun_cnt = 0;
	int          last_underrun = 0;

	i2s_codec_top dut (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.ac_mclk_o      (ac_mclk_o),
		.ac_bclk_o      (ac_bclk_o),
		.ac_lrclk_o     (ac_lrclk_o),
		.ac_dac_sdata_o (loop_sdata),
		.ac_adc_sdata_i (loop_sdata),
		.tx_push_i      (tx_push_i),
		.tx_frame_i     (tx_frame_i),
		.tx_credit_o    (tx_credit_o),
		.rx_valid_o     (rx_valid_o),
		.rx_frame_o     (rx_frame_o),
		.rx_ready_i     (rx_ready_i),
		.overrun_o      (overrun_o),
		.underrun_o     (underrun_o)
	);

	always #2 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw_sample(output tx_sample_t v);
		v = '0;
		for (int i = 0; i < `TX_SAMPLE_BITS; i++) begin
			v = {v[`TX_SAMPLE_BITS-2:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// Receiver keeps the top bits of each channel
	function automatic rx_frame_t expected_rx(input tx_frame_t f);
		rx_frame_t r;
		r.left  = f.left[`TX_SAMPLE_BITS-1 -: `RX_SAMPLE_BITS];
		r.right = f.right[`TX_SAMPLE_BITS-1 -: `RX_SAMPLE_BITS];
		return r;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("Error at cycle %0d: %s", cycle_cnt, msg);
	endtask

	task automatic end_run(input logic timed_out);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	task automatic check_idle(input string phase);
		check({phase, "_rx_valid"}, 64'd0, 64'(rx_valid_o));
		check({phase, "_tx_credit"}, 64'd0, 64'(tx_credit_o));
		check({phase, "_overrun"}, 64'd0, 64'(overrun_o));
		check({phase, "_underrun"}, 64'd0, 64'(underrun_o));
		check({phase, "_dac_sdata"}, 64'd0, 64'(loop_sdata));
		check({phase, "_mclk"}, 64'd0, 64'(ac_mclk_o));
		check({phase, "_bclk"}, 64'd0, 64'(ac_bclk_o));
		check({phase, "_lrclk"}, 64'd0, 64'(ac_lrclk_o));
	endtask

	// Toggle spacing of the three pin clocks
	task automatic measure_clocks(input int cycles);
		logic prev_m;
		logic prev_b;
		logic prev_l;
		int   last_m;
		int   last_b;
		int   last_l;
		int   n_m;
		int   n_b;
		int   n_l;
		prev_m = ac_mclk_o;
		prev_b = ac_bclk_o;
		prev_l = ac_lrclk_o;
		last_m = -1;   // First toggle only sets the origin
		last_b = -1;
		last_l = -1;
		n_m    = 0;
		n_b    = 0;
		n_l    = 0;
		repeat (cycles) begin
			@(posedge clk_i);
			if (ac_mclk_o != prev_m) begin
				if (last_m >= 0)
					check("mclk_toggle", 64'(`MCLK_DIV), 64'(cycle_cnt - last_m));
				last_m = cycle_cnt;
				n_m++;
			end
			if (ac_bclk_o != prev_b) begin
				if (last_b >= 0)
					check("bclk_toggle", 64'(`BCLK_DIV), 64'(cycle_cnt - last_b));
				last_b = cycle_cnt;
				n_b++;
			end
			if (ac_lrclk_o != prev_l) begin
				if (last_l >= 0)
					check("lrclk_toggle", 64'(`SLOT_BITS * 2 * `BCLK_DIV),
						64'(cycle_cnt - last_l));
				last_l = cycle_cnt;
				n_l++;
			end
			prev_m = ac_mclk_o;
			prev_b = ac_bclk_o;
			prev_l = ac_lrclk_o;
		end
		if (n_m < 2 || n_b < 2 || n_l < 2)
			report_error("a pin clock toggled too rarely to measure its spacing");
	endtask

	// Host model for the tx link
	always @(posedge clk_i) begin
		tx_frame_t frame;
		int        avail;
		tx_push_i <= 1'b0;
		if (rst_ni) begin
			avail = credits + (tx_credit_o ? 1 : 0);   // Returned credit is usable now
			if (host_en && avail > 0) begin
				draw_sample(frame.left);
				frame.left[0] = 1'b1;
				draw_sample(frame.right);
				tx_push_i  <= 1'b1;
				tx_frame_i <= frame;
				exp_q.push_back(expected_rx(frame));
				avail--;
			end
			credits = avail;
			if (credits < 0 || credits > `TX_FIFO_DEPTH)
				report_error($sformatf("host credit count out of range: %0d", credits));
		end
	end

	// Comparison of popped rx frames and event pulses
	always @(posedge clk_i) begin
		rx_frame_t got;
		rx_frame_t want;
		if (rst_ni) begin
			if (overrun_o)
				overrun_cnt++;
			if (underrun_o) begin
				if (!starving) begin
					report_error("underrun pulse while the host kept the tx FIFO fed");
				end else begin
					if (underrun_cnt > 0)
						check("underrun_spacing", 64'(FRAME_CYCLES),
							64'(cycle_cnt - last_underrun));
					underrun_cnt++;
					last_underrun = cycle_cnt;
				end
			end
			if (rx_valid_o && rx_ready_i) begin
				got = rx_frame_o;
				if (mode == M_SKIP && got != '0)
					mode = M_LOOP;   // First real frame lines up with the first push
				if (mode == M_LOOP || mode == M_HOLD) begin
					if (exp_q.size() == 0) begin
						report_error("rx frame popped with no tx frame pending");
					end else begin
						want = exp_q.pop_front();
						check(mode == M_LOOP ? "loopback" : "backpressure",
							64'(want), 64'(got));
					end
					matched++;
				end else if (mode == M_STARVE) begin
					zero_run = (got == '0) ? zero_run + 1 : 0;
				end
			end
		end
	end

	initial begin : watchdog
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		report_error($sformatf("timeout, run did not finish within %0d cycles",
			TIMEOUT_CYCLES));
		end_run(1'b1);
	end

	initial begin
		rst_ni     <= 1'b0;
		tx_push_i  <= 1'b0;
		tx_frame_i <= '0;
		rx_ready_i <= 1'b1;

		repeat (16) begin
			@(posedge clk_i);
			check_idle("reset");
		end
		rst_ni <= 1'b1;
		@(posedge clk_i);
		check_idle("after_reset");

		measure_clocks(4 * FRAME_CYCLES / 2);

		// Loopback with the rx side always ready
		wait (matched >= LOOP_FRAMES);

		// Rx back-pressure
		@(posedge clk_i);
		rx_ready_i <= 1'b0;
		@(negedge clk_i);
		mode        = M_HOLD;
		matched     = 0;
		overrun_cnt = 0;
		repeat (HOLD_FRAMES * FRAME_CYCLES) @(posedge clk_i);
		rx_ready_i <= 1'b1;
		wait (matched >= `RX_FIFO_DEPTH);
		@(negedge clk_i);
		mode = M_IGNORE;   // Frames after the drops no longer follow the queue
		if (overrun_cnt < 1)
			report_error("no overrun pulse while rx_ready_i was held low");

		// Tx starvation
		host_en  = 1'b0;
		starving = 1'b1;
		mode     = M_STARVE;
		zero_run = 0;
		wait (underrun_cnt >= 3 && zero_run >= 2);
		@(negedge clk_i);
		end_run(1'b0);
	end

endmodule

`default_nettype wire
